// ==== vic_loader.f ====
+incdir+include
hw/vic_loader_pkg.sv
hw/dl_router.sv
hw/prg_loader.sv
hw/cart_loader.sv
hw/tape_buffer.sv
hw/tape_fetch.sv
hw/byte_fifo.sv
hw/vic_loader_top.sv
verif/vic_loader_tb.sv

// ==== Bender.yml ====
package:
  name: vic_loader

sources:
  - include_dirs:
      - include
    files:
      - hw/vic_loader_pkg.sv
      - hw/dl_router.sv
      - hw/prg_loader.sv
      - hw/cart_loader.sv
      - hw/tape_buffer.sv
      - hw/tape_fetch.sv
      - hw/byte_fifo.sv
      - hw/vic_loader_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/vic_loader_tb.sv

// ==== verif/vic_loader_tb.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module vic_loader_tb import vic_loader_pkg::*; ();

	// Rough cycle cost of each test, reset state through unload
	localparam int TEST_CYCLES = 10 + 70 + 60 + 90 + 50 + 650 + 230;
	localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

	logic                  clk_sys;
	logic                  reset;
	logic                  dl_active_i;
	logic                  dl_wr_i;
	dl_beat_t              dl_beat_i;
	logic [`VL_DATA_W-1:0] dl_ext_i;
	ram_cfg_t              ram_cfg_i;
	logic                  play_toggle_i;
	logic                  unload_i;
	logic                  tape_pop_i;
	logic                  conf_wr_o;
	mem_wr_t               conf_o;
	mem_map_t              mem_map_o;
	logic [`VL_DATA_W-1:0] tape_byte_o;
	logic                  tape_empty_o;

	int          cyc = 0;
	int          err_cnt = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          test_err0;
	int          fall_cyc;
	int          tape_pos;
	logic [31:0] lfsr;
	logic [4:0]  exp_blk;
	logic [7:0]  shadow [0:65535];
	mem_wr_t     log_q[$];
	int          log_cyc_q[$];
	int          beat_cyc_q[$];
	logic [7:0]  file_q[$];
	logic [7:0]  tape_ref[$];

	// BASIC start, variable and array pointers, then the end-of-load pair
	logic [15:0] basic_ptr [0:7] = '{16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF};

	vic_loader_top dut_i (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// Shadow of the VIC memory, plus the order and cycle of every write
	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (conf_wr_o === 1'b1) begin
			shadow[conf_o.addr] <= conf_o.data;
			log_q.push_back(conf_o);
			log_cyc_q.push_back(cyc);
		end
	end

	always @(posedge clk_sys) begin
		if (cyc >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, a test did not finish", cyc);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Reference helpers

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [7:0] next_byte();
		logic       fb;
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			b = {b[6:0], fb};
		end
		return b;
	endfunction

	function automatic mem_wr_t make_wr(input logic [15:0] addr, input logic [7:0] data);
		mem_wr_t w;
		w.addr = addr;
		w.data = data;
		return w;
	endfunction

	// Regions 0 to 3 own flags 0 to 3, region 5 owns flag 4
	function automatic logic [4:0] block_flag(input logic [15:0] addr);
		if (addr[15:13] < 3'd4)
			return 5'b00001 << addr[15:13];
		if (addr[15:13] == 3'd5)
			return 5'b10000;
		return 5'b00000;
	endfunction

	function automatic mem_map_t expected_map(input ram_cfg_t cfg, input logic [4:0] blk);
		mem_map_t   m;
		logic [3:0] ram2_mask;
		ram2_mask = (4'd1 << cfg.ram2_sel) - 4'd1;
		m.ext = {cfg.ram3, ram2_mask[2:0], cfg.ram1} | blk;
		m.ro  = cfg.cart_writable ? 5'b00000 : blk;
		return m;
	endfunction

	//////////////////////////////////////////////////
	// Compare and bookkeeping

	task automatic report_failure(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	task automatic check_wr(input string sig, input mem_wr_t exp, input mem_wr_t got);
		if (got !== exp)
			report_failure($sformatf("error %s exp %h got %h", sig, exp, got));
	endtask

	task automatic check_map(input string sig, input mem_map_t exp, input mem_map_t got);
		if (got !== exp)
			report_failure($sformatf("error %s exp %h got %h", sig, exp, got));
	endtask

	task automatic check_tape(input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp)
			report_failure($sformatf("error tape_byte_o exp %h got %h", exp, got));
	endtask

	task automatic check_flag(input string sig, input logic exp, input logic got);
		if (got !== exp)
			report_failure($sformatf("error %s exp %h got %h", sig, exp, got));
	endtask

	task automatic check_cycle(input int idx, input int exp);
		if (log_cyc_q[idx] != exp)
			report_failure($sformatf("Configuration write %0d came in cycle %0d, not in cycle %0d",
				idx, log_cyc_q[idx], exp));
	endtask

	task automatic start_test();
		test_err0 = err_cnt;
		log_q.delete();
		log_cyc_q.delete();
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == test_err0) begin
			pass_cnt++;
			$display("PASS %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s, %0d errors", name, err_cnt - test_err0);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus

	// Sends file_q as one download, one beat per cycle
	task automatic send_file(input logic [7:0] idx, input logic [7:0] ext);
		beat_cyc_q.delete();
		@(negedge clk_sys);
		dl_active_i     = 1'b1;
		dl_ext_i        = ext;
		dl_beat_i.index = idx;
		for (int i = 0; i < file_q.size(); i++) begin
			@(negedge clk_sys);
			dl_wr_i        = 1'b1;
			dl_beat_i.addr = i[24:0];
			dl_beat_i.data = file_q[i];
			beat_cyc_q.push_back(cyc);
		end
		@(negedge clk_sys);
		dl_wr_i     = 1'b0;
		dl_active_i = 1'b0;
		fall_cyc    = cyc;
	endtask

	task automatic wait_log(input int n, input int limit);
		int waited;
		waited = 0;
		while (log_q.size() < n && waited < limit) begin
			@(negedge clk_sys);
			waited++;
		end
		if (log_q.size() < n)
			report_failure($sformatf("Only %0d of %0d configuration writes arrived",
				log_q.size(), n));
	endtask

	// Pops the FIFO head if there is one, checked against the tape model
	task automatic pop_if_ready(output logic popped);
		tape_pop_i = 1'b0;
		popped     = 1'b0;
		if (!tape_empty_o) begin
			if (tape_pos < tape_ref.size())
				check_tape(tape_ref[tape_pos], tape_byte_o);
			else
				report_failure("Tape FIFO returned more bytes than were loaded");
			tape_pos++;
			tape_pop_i = 1'b1;
			popped     = 1'b1;
		end
	endtask

	task automatic pop_bytes(input int n);
		int   target;
		int   waited;
		logic popped;
		target = tape_pos + n;
		waited = 0;
		while (tape_pos < target && waited < n * 8 + 40) begin
			@(negedge clk_sys);
			pop_if_ready(popped);
			waited++;
		end
		@(negedge clk_sys);
		tape_pop_i = 1'b0;
		if (tape_pos < target)
			report_failure($sformatf("Tape bytes stopped at %0d, %0d expected", tape_pos, target));
	endtask

	// Empties the FIFO until nothing more arrives for 8 cycles
	task automatic drain_tape();
		int   idle;
		int   waited;
		logic popped;
		idle   = 0;
		waited = 0;
		while (idle < 8 && waited < 100) begin
			@(negedge clk_sys);
			pop_if_ready(popped);
			idle = popped ? 0 : idle + 1;
			waited++;
		end
		@(negedge clk_sys);
		tape_pop_i = 1'b0;
	endtask

	task automatic stay_empty(input int n, input string msg);
		logic seen;
		seen = 1'b0;
		repeat (n) begin
			@(negedge clk_sys);
			if (tape_empty_o !== 1'b1)
				seen = 1'b1;
		end
		if (seen)
			report_failure(msg);
	endtask

	//////////////////////////////////////////////////
	// Tests

	task automatic test_reset();
		start_test();
		check_flag("conf_wr_o", 1'b0, conf_wr_o);
		check_map("mem_map_o", expected_map(ram_cfg_i, 5'b00000), mem_map_o);
		check_flag("tape_empty_o", 1'b1, tape_empty_o);
		finish_test("reset state");
	endtask

	task automatic test_prg(input logic [15:0] load, input int count, input string name);
		int          n_wr;
		logic [15:0] end_addr;
		logic [7:0]  exp;
		start_test();
		file_q.delete();
		file_q.push_back(load[7:0]);
		file_q.push_back(load[15:8]);
		for (int i = 0; i < count; i++)
			file_q.push_back(next_byte());
		// Bytes stop at the BASIC limit
		n_wr = int'(`VL_PRG_LIMIT) - int'(load);
		if (n_wr > count)
			n_wr = count;
		end_addr = load + n_wr[15:0];
		send_file(`VL_IDX_PRG, 8'h00);
		wait_log(n_wr + 8, 60);
		if (log_q.size() >= n_wr + 8) begin
			for (int i = 0; i < n_wr; i++) begin
				check_wr("conf_o", make_wr(load + i[15:0], file_q[i + 2]), log_q[i]);
				check_cycle(i, beat_cyc_q[i + 2] + 2);
			end
			for (int k = 0; k < 8; k++) begin
				exp = k[0] ? end_addr[15:8] : end_addr[7:0];
				check_wr("conf_o", make_wr(basic_ptr[k], exp), log_q[n_wr + k]);
				check_cycle(n_wr + k, fall_cyc + 3 + 2 * k);
				check_wr("shadow", make_wr(basic_ptr[k], exp),
					make_wr(basic_ptr[k], shadow[basic_ptr[k]]));
			end
		end
		finish_test(name);
	endtask

	task automatic test_cart(input logic [7:0] idx, input logic [7:0] ext,
			input logic [15:0] start, input int count, input ram_cfg_t cfg_after,
			input string name);
		int skip;
		start_test();
		file_q.delete();
		skip = 0;
		if (idx == `VL_IDX_CRT) begin
			file_q.push_back(start[7:0]);
			file_q.push_back(start[15:8]);
			skip = 2;
		end
		for (int i = 0; i < count; i++)
			file_q.push_back(next_byte());
		send_file(idx, ext);
		wait_log(count, 40);
		if (log_q.size() >= count) begin
			for (int i = 0; i < count; i++) begin
				check_wr("conf_o", make_wr(start + i[15:0], file_q[i + skip]), log_q[i]);
				check_cycle(i, beat_cyc_q[i + skip] + 2);
				exp_blk = exp_blk | block_flag(start + i[15:0]);
			end
		end
		check_map("mem_map_o", expected_map(ram_cfg_i, exp_blk), mem_map_o);
		// New user settings on top of the recorded blocks
		@(negedge clk_sys);
		ram_cfg_i = cfg_after;
		@(negedge clk_sys);
		check_map("mem_map_o", expected_map(cfg_after, exp_blk), mem_map_o);
		finish_test(name);
	endtask

	task automatic test_tape_play();
		logic [7:0] b;
		start_test();
		file_q.delete();
		tape_ref.delete();
		tape_pos = 0;
		for (int i = 0; i < 100; i++) begin
			b = next_byte();
			file_q.push_back(b);
			tape_ref.push_back(b);
		end
		send_file(`VL_IDX_TAP, 8'h00);
		pop_bytes(30);
		@(negedge clk_sys);
		play_toggle_i = 1'b1;
		@(negedge clk_sys);
		play_toggle_i = 1'b0;
		drain_tape();
		if (tape_pos >= 100)
			report_failure("Tape played to the end in spite of the pause");
		stay_empty(20, "Tape bytes kept coming while playback was paused");
		@(negedge clk_sys);
		play_toggle_i = 1'b1;
		@(negedge clk_sys);
		play_toggle_i = 1'b0;
		if (tape_pos < 100)
			pop_bytes(100 - tape_pos);
		stay_empty(30, "Tape FIFO filled again after the last byte");
		finish_test("tape load and playback");
	endtask

	task automatic test_unload();
		logic [7:0] b;
		start_test();
		file_q.delete();
		tape_ref.delete();
		tape_pos = 0;
		for (int i = 0; i < 40; i++) begin
			b = next_byte();
			file_q.push_back(b);
			tape_ref.push_back(b);
		end
		send_file(`VL_IDX_TAP, 8'h00);
		pop_bytes(10);
		@(negedge clk_sys);
		unload_i = 1'b1;
		@(negedge clk_sys);
		unload_i = 1'b0;
		stay_empty(40, "Tape FIFO held bytes after the unload");
		finish_test("unload");
	endtask

	//////////////////////////////////////////////////
	// Sequence

	initial begin
		ram_cfg_t cfg_wr;
		ram_cfg_t cfg_ram;
		lfsr          = 32'hfff0_bac6;
		exp_blk       = 5'b00000;
		reset         = 1'b1;
		dl_active_i   = 1'b0;
		dl_wr_i       = 1'b0;
		dl_beat_i     = '0;
		dl_ext_i      = 8'h00;
		ram_cfg_i     = '0;
		play_toggle_i = 1'b0;
		unload_i      = 1'b0;
		tape_pop_i    = 1'b0;
		cfg_wr        = '0;
		cfg_wr.cart_writable = 1'b1;
		cfg_ram       = '0;
		cfg_ram.ram1     = 1'b1;
		cfg_ram.ram2_sel = 2'd2;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		test_reset();
		test_prg(16'h1001, 40, "PRG load with pointer patch");
		test_prg(16'h9FF0, 32, "PRG limit");
		test_cart(`VL_IDX_CRT, 8'h00, 16'hA000, 64, cfg_wr, "cartridge with header");
		test_cart(`VL_IDX_CRT_RAW, "6", 16'h6000, 24, cfg_ram, "raw cartridge and memory map");
		test_tape_play();
		test_unload();

		$display("%0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== hw/vic_loader_top.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module vic_loader_top import vic_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  dl_beat_t              dl_beat_i,
	input  logic [`VL_DATA_W-1:0] dl_ext_i,
	input  ram_cfg_t              ram_cfg_i,
	input  logic                  play_toggle_i,
	input  logic                  unload_i,
	input  logic                  tape_pop_i,
	output logic                  conf_wr_o,
	output mem_wr_t               conf_o,
	output mem_map_t              mem_map_o,
	output logic [`VL_DATA_W-1:0] tape_byte_o,
	output logic                  tape_empty_o
);

	logic                   rt_active;
	dl_beat_t               rt_beat;
	logic [`VL_IDX_W-1:0]   rt_index;
	logic                   prg_wr;
	logic                   cart_wr;
	logic                   tape_wr;
	logic                   prg_conf_wr;
	mem_wr_t                prg_conf;
	logic                   cart_conf_wr;
	mem_wr_t                cart_conf;
	logic                   tape_rd;
	logic [`VL_TAPE_AW-1:0] tape_rd_addr;
	logic [`VL_DATA_W-1:0]  tape_rd_data;
	logic                   tape_rd_valid;
	logic                   fifo_push;
	logic [`VL_DATA_W-1:0]  fifo_push_data;
	logic                   fifo_full;
	logic                   fifo_clr;

	// Old tape bytes are dropped on unload and while a new tape loads
	assign fifo_clr = reset | unload_i | (rt_active & (rt_index == `VL_IDX_TAP));

	dl_router router_i (
		.clk_sys, .reset, .dl_active_i, .dl_wr_i, .dl_beat_i,
		.prg_wr_i(prg_conf_wr), .prg_i(prg_conf),
		.cart_wr_i(cart_conf_wr), .cart_i(cart_conf),
		.rt_active_o(rt_active), .rt_beat_o(rt_beat),
		.prg_wr_o(prg_wr), .cart_wr_o(cart_wr), .tape_wr_o(tape_wr),
		.rt_index_o(rt_index), .conf_wr_o, .conf_o
	);

	prg_loader prg_i (
		.clk_sys, .reset, .rt_active_i(rt_active), .rt_index_i(rt_index),
		.beat_wr_i(prg_wr), .beat_i(rt_beat),
		.wr_o(prg_conf_wr), .wr_data_o(prg_conf)
	);

	cart_loader cart_i (
		.clk_sys, .reset, .rt_active_i(rt_active), .rt_index_i(rt_index),
		.dl_ext_i, .ram_cfg_i, .beat_wr_i(cart_wr), .beat_i(rt_beat),
		.wr_o(cart_conf_wr), .wr_data_o(cart_conf), .mem_map_o
	);

	tape_buffer buffer_i (
		.clk_sys, .wr_i(tape_wr),
		.wr_addr_i(rt_beat.addr[`VL_TAPE_AW-1:0]), .wr_data_i(rt_beat.data),
		.rd_i(tape_rd), .rd_addr_i(tape_rd_addr),
		.rd_data_o(tape_rd_data), .rd_valid_o(tape_rd_valid)
	);

	tape_fetch fetch_i (
		.clk_sys, .reset, .rt_active_i(rt_active), .rt_index_i(rt_index),
		.beat_wr_i(tape_wr), .beat_i(rt_beat), .play_toggle_i, .unload_i,
		.fifo_full_i(fifo_full), .fifo_empty_i(tape_empty_o),
		.rd_valid_i(tape_rd_valid), .rd_data_i(tape_rd_data),
		.rd_o(tape_rd), .rd_addr_o(tape_rd_addr),
		.push_o(fifo_push), .push_data_o(fifo_push_data)
	);

	byte_fifo fifo_i (
		.clk_sys, .reset(fifo_clr), .push_i(fifo_push), .push_data_i(fifo_push_data),
		.pop_i(tape_pop_i), .head_o(tape_byte_o), .full_o(fifo_full), .empty_o(tape_empty_o)
	);

endmodule

// ==== hw/byte_fifo.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module byte_fifo (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  push_i,
	input  logic [`VL_DATA_W-1:0] push_data_i,
	input  logic                  pop_i,
	output logic [`VL_DATA_W-1:0] head_o,
	output logic                  full_o,
	output logic                  empty_o
);

	localparam int DEPTH = 2 ** `VL_FIFO_AW;

	logic [`VL_DATA_W-1:0]  mem [0:DEPTH-1];
	logic [`VL_FIFO_AW:0]   wr_ptr;
	logic [`VL_FIFO_AW:0]   rd_ptr;
	logic                   do_push;
	logic                   do_pop;

	// Extra pointer bit tells full from empty
	assign full_o  = (wr_ptr[`VL_FIFO_AW] != rd_ptr[`VL_FIFO_AW]) &&
		(wr_ptr[`VL_FIFO_AW-1:0] == rd_ptr[`VL_FIFO_AW-1:0]);
	assign empty_o = (wr_ptr == rd_ptr);
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;
	assign head_o  = mem[rd_ptr[`VL_FIFO_AW-1:0]];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr[`VL_FIFO_AW-1:0]] <= push_data_i;
	end

endmodule

// ==== hw/tape_fetch.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module tape_fetch import vic_loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   rt_active_i,
	input  logic [`VL_IDX_W-1:0]   rt_index_i,
	input  logic                   beat_wr_i,
	input  dl_beat_t               beat_i,
	input  logic                   play_toggle_i,
	input  logic                   unload_i,
	input  logic                   fifo_full_i,
	input  logic                   fifo_empty_i,
	input  logic                   rd_valid_i,
	input  logic [`VL_DATA_W-1:0]  rd_data_i,
	output logic                   rd_o,
	output logic [`VL_TAPE_AW-1:0] rd_addr_o,
	output logic                   push_o,
	output logic [`VL_DATA_W-1:0]  push_data_o
);

	logic [`VL_TAPE_AW:0] tape_len;
	logic [`VL_TAPE_AW:0] play_addr;
	logic                 active_q;
	logic                 play;
	logic                 wait_rd;
	logic                 loading;
	logic                 dl_end;
	logic                 all_fetched;
	logic                 finish;

	assign loading     = rt_active_i && (rt_index_i == `VL_IDX_TAP);
	assign dl_end      = active_q && !rt_active_i && (rt_index_i == `VL_IDX_TAP);
	assign all_fetched = (play_addr >= tape_len);
	// Nothing left in flight and the cassette has drained the FIFO
	assign finish      = all_fetched & ~wait_rd & ~push_o & fifo_empty_i;
	assign rd_addr_o   = play_addr[`VL_TAPE_AW-1:0];

	//////////////////////////////////////////////////
	// Tape length

	always_ff @(posedge clk_sys) begin
		if (reset || unload_i) begin
			active_q <= 1'b0;
			tape_len <= '0;
		end else begin
			active_q <= rt_active_i;
			if (beat_wr_i)
				tape_len <= {1'b0, beat_i.addr[`VL_TAPE_AW-1:0]} + 1'b1;
			else if (loading && !active_q)
				tape_len <= '0;
		end
	end

	//////////////////////////////////////////////////
	// Play state and fetch loop

	always_ff @(posedge clk_sys) begin
		if (reset || unload_i || loading) begin
			play      <= 1'b0;
			play_addr <= '0;
			wait_rd   <= 1'b0;
			rd_o      <= 1'b0;
			push_o    <= 1'b0;
		end else begin
			rd_o   <= 1'b0;
			push_o <= 1'b0;
			if (dl_end)
				play <= 1'b1;
			else if (play_toggle_i)
				play <= ~play;
			else if (play && finish)
				play <= 1'b0;

			// A pending read completes even when paused
			if (wait_rd) begin
				if (rd_valid_i) begin
					push_o    <= 1'b1;
					play_addr <= play_addr + 1'b1;
					wait_rd   <= 1'b0;
				end
			end else if (play && !push_o && !all_fetched && !fifo_full_i) begin
				rd_o    <= 1'b1;
				wait_rd <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wait_rd && rd_valid_i)
			push_data_o <= rd_data_i;
	end

endmodule

// ==== hw/tape_buffer.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module tape_buffer (
	input  logic                   clk_sys,
	input  logic                   wr_i,
	input  logic [`VL_TAPE_AW-1:0] wr_addr_i,
	input  logic [`VL_DATA_W-1:0]  wr_data_i,
	input  logic                   rd_i,
	input  logic [`VL_TAPE_AW-1:0] rd_addr_i,
	output logic [`VL_DATA_W-1:0]  rd_data_o,
	output logic                   rd_valid_o
);

	localparam int DEPTH = 2 ** `VL_TAPE_AW;

	logic [`VL_DATA_W-1:0] mem [0:DEPTH-1];

	// Single port, downloads and playback never overlap
	always_ff @(posedge clk_sys) begin
		if (wr_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	always_ff @(posedge clk_sys) begin
		if (rd_i)
			rd_data_o <= mem[rd_addr_i];
	end

	// Data is valid the cycle after the read strobe
	always_ff @(posedge clk_sys) begin
		rd_valid_o <= rd_i;
	end

endmodule

// ==== hw/cart_loader.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module cart_loader import vic_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  rt_active_i,
	input  logic [`VL_IDX_W-1:0]  rt_index_i,
	input  logic [`VL_DATA_W-1:0] dl_ext_i,
	input  ram_cfg_t              ram_cfg_i,
	input  logic                  beat_wr_i,
	input  dl_beat_t              beat_i,
	output logic                  wr_o,
	output mem_wr_t               wr_data_o,
	output mem_map_t              mem_map_o
);

	logic [`VL_ADDR_W-1:0] load_addr;
	logic                  active_q;
	logic                  has_hdr;
	logic [4:0]            blk;
	logic [2:0]            ram2_blk;
	logic                  dl_start;
	logic                  raw_start;
	logic                  hdr_lo;
	logic                  hdr_hi;
	logic                  data_wr;

	// 8 KB region to block flag, region 4 has none
	function automatic logic [4:0] blk_bit(input logic [2:0] region);
		case (region)
			3'd0:    return 5'b00001;
			3'd1:    return 5'b00010;
			3'd2:    return 5'b00100;
			3'd3:    return 5'b01000;
			3'd5:    return 5'b10000;
			default: return 5'b00000;
		endcase
	endfunction

	assign dl_start  = ~active_q & rt_active_i;
	assign raw_start = dl_start && (rt_index_i == `VL_IDX_CRT_RAW);
	assign hdr_lo    = beat_wr_i && has_hdr && (beat_i.addr == '0);
	assign hdr_hi    = beat_wr_i && has_hdr && (beat_i.addr == `VL_DL_ADDR_W'(1));
	assign data_wr   = beat_wr_i && !hdr_lo && !hdr_hi && (load_addr < `VL_CART_LIMIT);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			has_hdr  <= 1'b0;
			blk      <= '0;
			wr_o     <= 1'b0;
		end else begin
			active_q <= rt_active_i;
			wr_o     <= data_wr;
			if (dl_start && (rt_index_i == `VL_IDX_CRT))
				has_hdr <= 1'b1;
			else if (raw_start)
				has_hdr <= 1'b0;
			if (data_wr)
				blk <= blk | blk_bit(load_addr[15:13]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (raw_start) begin
			// Extension digit picks the 4 KB page
			if ((dl_ext_i >= "2") && (dl_ext_i <= "9"))
				load_addr <= {dl_ext_i[3:0], 12'h000};
			else if ((dl_ext_i >= "A") && (dl_ext_i <= "B"))
				load_addr <= {dl_ext_i[3:0] + 4'd9, 12'h000};
		end else if (hdr_lo) begin
			load_addr[7:0] <= beat_i.data;
		end else if (hdr_hi) begin
			load_addr[15:8] <= beat_i.data;
		end else if (data_wr) begin
			wr_data_o.addr <= load_addr;
			wr_data_o.data <= beat_i.data;
			load_addr      <= load_addr + 16'd1;
		end
	end

	// RAM2 option fills blocks 1..3 from the bottom
	always_comb begin
		case (ram_cfg_i.ram2_sel)
			2'd0:    ram2_blk = 3'b000;
			2'd1:    ram2_blk = 3'b001;
			2'd2:    ram2_blk = 3'b011;
			default: ram2_blk = 3'b111;
		endcase
	end

	assign mem_map_o.ext = {ram_cfg_i.ram3, ram2_blk, ram_cfg_i.ram1} | blk;
	assign mem_map_o.ro  = blk & ~{5{ram_cfg_i.cart_writable}};

endmodule

// ==== hw/prg_loader.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module prg_loader import vic_loader_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 rt_active_i,
	input  logic [`VL_IDX_W-1:0] rt_index_i,
	input  logic                 beat_wr_i,
	input  dl_beat_t             beat_i,
	output logic                 wr_o,
	output mem_wr_t              wr_data_o
);

	logic [`VL_ADDR_W-1:0] load_addr;
	logic                  active_q;
	logic [3:0]            patch_step;
	logic [2:0]            ptr_sel;
	logic                  dl_end;
	logic                  hdr_lo;
	logic                  hdr_hi;
	logic                  data_wr;

	// BASIC pointers 0x2D..0x32 followed by 0xAE/0xAF
	function automatic logic [`VL_ADDR_W-1:0] ptr_addr(input logic [2:0] sel);
		if (sel < 3'd6)
			return 16'h002D + {13'd0, sel};
		return 16'h00A8 + {13'd0, sel};
	endfunction

	assign dl_end  = active_q & ~rt_active_i & (rt_index_i == `VL_IDX_PRG);
	assign ptr_sel = patch_step[3:1];

	// Two header bytes carry the load address
	assign hdr_lo  = beat_wr_i && (beat_i.addr == '0);
	assign hdr_hi  = beat_wr_i && (beat_i.addr == `VL_DL_ADDR_W'(1));
	assign data_wr = beat_wr_i && !hdr_lo && !hdr_hi && (load_addr < `VL_PRG_LIMIT);

	//////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q   <= 1'b0;
			patch_step <= '0;
			wr_o       <= 1'b0;
		end else begin
			active_q <= rt_active_i;
			if (dl_end)
				patch_step <= 4'd1;
			else if (patch_step != 4'd0)
				patch_step <= patch_step + 4'd1;
			// Odd steps write, even steps idle
			wr_o <= data_wr | patch_step[0];
		end
	end

	//////////////////////////////////////////////////
	// Address and write data

	always_ff @(posedge clk_sys) begin
		if (hdr_lo) begin
			load_addr[7:0] <= beat_i.data;
		end else if (hdr_hi) begin
			load_addr[15:8] <= beat_i.data;
		end else if (data_wr) begin
			wr_data_o.addr <= load_addr;
			wr_data_o.data <= beat_i.data;
			load_addr      <= load_addr + 16'd1;
		end else if (patch_step[0]) begin
			wr_data_o.addr <= ptr_addr(ptr_sel);
			// Even pointers take the low byte
			wr_data_o.data <= ptr_sel[0] ? load_addr[15:8] : load_addr[7:0];
		end
	end

endmodule

// ==== hw/dl_router.sv ====
`timescale 1ns/1ps
`include "vic_loader_defines.svh"

module dl_router import vic_loader_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active_i,
	input  logic                 dl_wr_i,
	input  dl_beat_t             dl_beat_i,
	input  logic                 prg_wr_i,
	input  mem_wr_t              prg_i,
	input  logic                 cart_wr_i,
	input  mem_wr_t              cart_i,
	output logic                 rt_active_o,
	output dl_beat_t             rt_beat_o,
	output logic                 prg_wr_o,
	output logic                 cart_wr_o,
	output logic                 tape_wr_o,
	output logic [`VL_IDX_W-1:0] rt_index_o,
	output logic                 conf_wr_o,
	output mem_wr_t              conf_o
);

	logic beat_ok;

	assign beat_ok = dl_wr_i & dl_active_i;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rt_active_o <= 1'b0;
			rt_index_o  <= '0;
			prg_wr_o    <= 1'b0;
			cart_wr_o   <= 1'b0;
			tape_wr_o   <= 1'b0;
		end else begin
			rt_active_o <= dl_active_i;
			// Index is held after the download so the loaders see the falling edge
			if (dl_active_i)
				rt_index_o <= dl_beat_i.index;
			prg_wr_o  <= beat_ok && (dl_beat_i.index == `VL_IDX_PRG);
			cart_wr_o <= beat_ok && ((dl_beat_i.index == `VL_IDX_CRT) ||
				(dl_beat_i.index == `VL_IDX_CRT_RAW));
			tape_wr_o <= beat_ok && (dl_beat_i.index == `VL_IDX_TAP);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i)
			rt_beat_o <= dl_beat_i;
	end

	// Only one loader is ever active
	assign conf_wr_o = prg_wr_i | cart_wr_i;
	assign conf_o    = prg_wr_i ? prg_i : cart_i;

endmodule

// ==== hw/vic_loader_pkg.sv ====
`include "vic_loader_defines.svh"

package vic_loader_pkg;

	// One byte of a download as it comes from the host
	typedef struct packed {
		logic [`VL_IDX_W-1:0]     index;
		logic [`VL_DL_ADDR_W-1:0] addr;
		logic [`VL_DATA_W-1:0]    data;
	} dl_beat_t;

	// Write into the VIC memory configuration port
	typedef struct packed {
		logic [`VL_ADDR_W-1:0] addr;
		logic [`VL_DATA_W-1:0] data;
	} mem_wr_t;

	// Expansion RAM options chosen by the user
	typedef struct packed {
		logic       ram1;
		logic [1:0] ram2_sel;
		logic       ram3;
		logic       cart_writable;
	} ram_cfg_t;

	// Block enables and read-only flags for the five expansion blocks
	typedef struct packed {
		logic [4:0] ext;
		logic [4:0] ro;
	} mem_map_t;

endpackage

// ==== include/vic_loader_defines.svh ====
`ifndef VIC_LOADER_DEFINES_SVH
`define VIC_LOADER_DEFINES_SVH

// Download stream and VIC bus widths
`define VL_IDX_W      8
`define VL_DL_ADDR_W  25
`define VL_ADDR_W     16
`define VL_DATA_W     8

// Download indices as sent by the host
`define VL_IDX_PRG     8'd1
`define VL_IDX_CRT     8'd2
`define VL_IDX_CRT_RAW 8'd3
`define VL_IDX_TAP     8'd5

// First addresses that may not be written
`define VL_PRG_LIMIT  16'hA000
`define VL_CART_LIMIT 16'hC000

// 4096 byte tape buffer, 16 entry FIFO
`define VL_TAPE_AW    12
`define VL_FIFO_AW    4

`endif
